//--- opn_pkg.sv
// Shared constants and types for the OPN control block
// Register map, prescaler ratios, timer widths

package opn_pkg;

    // Timer register map, lower bank
    localparam logic [7:0] REG_TA_HI     = 8'h24;
    localparam logic [7:0] REG_TA_LO     = 8'h25;
    localparam logic [7:0] REG_TB        = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL = 8'h27;

    // Prescaler chain
    localparam int CEN_DIV          = 6;   // cen pulses per slot
    localparam int SLOTS_PER_SAMPLE = 24;  // slots per timer A tick
    localparam int TB_PRESCALE      = 16;  // timer A ticks per timer B tick

    // Busy time after a data write, in slots
    localparam int BUSY_SLOTS = 32;

    // Timer widths
    localparam int TA_W = 10;
    localparam int TB_W = 8;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    typedef logic [TA_W-1:0] ta_value_t;
    typedef logic [TB_W-1:0] tb_value_t;

    // Busy in bit 7, flag B in bit 1, flag A in bit 0
    typedef logic [7:0] status_t;

endpackage

//--- timer_if.sv
// Settings and overflow flag of one interval timer

`timescale 1ns/1ns

interface timer_if #(
    parameter int width = opn_pkg::TA_W
);

    logic [width-1:0] value;  // Start value
    logic             load;   // Timer runs while high
    logic             enable; // Overflow may set the flag
    logic             clear;  // One clk pulse
    logic             flag;

    modport regs (
        output value, load, enable, clear,
        input  flag
    );

    modport timer (
        input  value, load, enable, clear,
        output flag
    );

endinterface

//--- opn_clk_div.sv
// Prescaler chain: cen to slot enable, slot enable to timer A and B ticks

`timescale 1ns/1ns

module opn_clk_div (
    input  logic clk,
    input  logic reset,
    input  logic cen,
    output logic slot_en,
    output logic tick_a,
    output logic tick_b
);

    logic [$clog2(opn_pkg::CEN_DIV)-1:0]          cen_cnt;
    logic [$clog2(opn_pkg::SLOTS_PER_SAMPLE)-1:0] slot_cnt;
    logic [$clog2(opn_pkg::TB_PRESCALE)-1:0]      b_cnt;
    logic cen_wrap, slot_wrap, b_wrap;

    assign cen_wrap  = cen_cnt == opn_pkg::CEN_DIV - 1;
    assign slot_wrap = slot_cnt == opn_pkg::SLOTS_PER_SAMPLE - 1;
    assign b_wrap    = b_cnt == opn_pkg::TB_PRESCALE - 1;

    // Stage 1, counts cen
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt <= '0;
            slot_en <= 1'b0;
        end else begin
            slot_en <= cen && cen_wrap;
            if (cen) begin
                cen_cnt <= cen_wrap ? '0 : cen_cnt + 1'b1;
            end
        end
    end

    // Stage 2, counts slots
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_cnt <= '0;
            tick_a   <= 1'b0;
        end else begin
            tick_a <= slot_en && slot_wrap;
            if (slot_en) begin
                slot_cnt <= slot_wrap ? '0 : slot_cnt + 1'b1;
            end
        end
    end

    // Stage 3, counts timer A ticks
    always_ff @(posedge clk) begin
        if (reset) begin
            b_cnt  <= '0;
            tick_b <= 1'b0;
        end else begin
            tick_b <= tick_a && b_wrap;
            if (tick_a) begin
                b_cnt <= b_wrap ? '0 : b_cnt + 1'b1;
            end
        end
    end

    // Each tick_a follows a slot that wrapped the slot counter
    a_tick_from_slot: assert property (
        @(posedge clk) disable iff (reset)
        tick_a |-> $past(slot_en) && slot_cnt == '0
    );

endmodule

//--- opn_regs.sv
// CPU bus decode, timer register bank and control pulses
// Busy counter, status byte and interrupt output

`timescale 1ns/1ns

module opn_regs (
    input  logic               clk,
    input  logic               reset,
    input  opn_pkg::reg_data_t din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    input  logic               slot_en,
    timer_if.regs              ta,
    timer_if.regs              tb,
    output opn_pkg::status_t   dout,
    output logic               irq_n
);

    logic write;
    logic addr_wr;   // Address phase, lower bank
    logic data_wr;   // Data phase, either bank
    logic lower_wr;  // Data phase, lower bank only
    logic ctl_wr;

    opn_pkg::reg_addr_t reg_sel;  // Latched register address

    // Timer values
    opn_pkg::reg_data_t ta_hi;
    logic [1:0]         ta_lo;
    opn_pkg::ta_value_t ta_val;
    opn_pkg::tb_value_t tb_val;

    // Control byte fields
    logic load_a, load_b;
    logic en_a, en_b;
    logic clr_a, clr_b;

    logic [$clog2(opn_pkg::BUSY_SLOTS)-1:0] busy_cnt;
    logic busy;
    logic flag_a_q, flag_b_q;

    assign write    = !cs_n && !wr_n;
    assign addr_wr  = write && !addr[0] && !addr[1];
    assign data_wr  = write && addr[0];
    assign lower_wr = data_wr && !addr[1];  // Upper bank is not kept
    assign ctl_wr   = lower_wr && (reg_sel == opn_pkg::REG_TIMER_CTL);

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_sel <= '0;
        end else if (addr_wr) begin
            reg_sel <= din;
        end
    end

    // Timer value bytes
    always_ff @(posedge clk) begin
        if (lower_wr) begin
            case (reg_sel)
                opn_pkg::REG_TA_HI: ta_hi  <= din;
                opn_pkg::REG_TA_LO: ta_lo  <= din[1:0];
                opn_pkg::REG_TB:    tb_val <= din;
                default: ;  // Other addresses hold nothing here
            endcase
        end
    end

    assign ta_val = {ta_hi, ta_lo};

    // Timer control, 27h
    always_ff @(posedge clk) begin
        if (reset) begin
            load_a <= 1'b0;
            load_b <= 1'b0;
            en_a   <= 1'b0;
            en_b   <= 1'b0;
            clr_a  <= 1'b0;
            clr_b  <= 1'b0;
        end else begin
            clr_a <= ctl_wr && din[4];  // Flag clears are strobes
            clr_b <= ctl_wr && din[5];
            if (ctl_wr) begin
                load_a <= din[0];
                load_b <= din[1];
                en_a   <= din[2];
                en_b   <= din[3];
            end
        end
    end

    assign ta.value  = ta_val;
    assign ta.load   = load_a;
    assign ta.enable = en_a;
    assign ta.clear  = clr_a;

    assign tb.value  = tb_val;
    assign tb.load   = load_b;
    assign tb.enable = en_b;
    assign tb.clear  = clr_b;

    // Busy lasts BUSY_SLOTS slots, each data write restarts it
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (busy && slot_en) begin
            busy_cnt <= busy_cnt + 1'b1;
            if (busy_cnt == opn_pkg::BUSY_SLOTS - 1) begin
                busy <= 1'b0;
            end
        end
    end

    // Status stage, one cycle behind the timer flags
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_a_q <= 1'b0;
            flag_b_q <= 1'b0;
            irq_n    <= 1'b1;
        end else begin
            flag_a_q <= ta.flag;
            flag_b_q <= tb.flag;
            irq_n    <= !(ta.flag || tb.flag);
        end
    end

    // Read back ignores addr
    assign dout = {busy, 5'b00000, flag_b_q, flag_a_q};

    // A control write clears a flag with a single-cycle strobe
    clr_a_single: assert property (
        @(posedge clk) disable iff (reset) ta.clear |=> !ta.clear
    );
    clr_b_single: assert property (
        @(posedge clk) disable iff (reset) tb.clear |=> !tb.clear
    );

endmodule

//--- opn_timer.sv
// Up-counting interval timer with reload and overflow flag

`timescale 1ns/1ns

module opn_timer #(
    parameter int width = opn_pkg::TA_W
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   tick,
    timer_if.timer ctl
);

    logic [width-1:0] cnt;
    logic             load_q;     // load seen last cycle
    logic             load_rise;
    logic             overflow;
    logic             flag;

    assign load_rise = ctl.load && !load_q;
    assign overflow  = &cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            load_q <= 1'b0;
            flag   <= 1'b0;
        end else begin
            load_q <= ctl.load;
            if (load_rise) begin
                cnt <= ctl.value;       // Start from the programmed value
            end else if (ctl.load && tick) begin
                if (overflow) begin
                    cnt <= ctl.value;   // Reload keeps the period
                    if (ctl.enable) begin
                        flag <= 1'b1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            // Clear wins over a set in the same cycle
            if (ctl.clear) begin
                flag <= 1'b0;
            end
        end
    end

    assign ctl.flag = flag;

    // Flag rises only from an enabled overflow, which reloads the counter
    flag_needs_enable: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ctl.flag) |-> $past(ctl.enable) && cnt == $past(ctl.value)
    );

endmodule

//--- opn_core.sv
// Top level of the OPN control block
// Prescaler, register bank and the two interval timers

`timescale 1ns/1ns

module opn_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               cen,      // External clock enable
    input  opn_pkg::reg_data_t din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    output opn_pkg::status_t   dout,
    output logic               irq_n
);

    logic slot_en;
    logic tick_a;
    logic tick_b;

    timer_if #(.width(opn_pkg::TA_W)) ta_if ();
    timer_if #(.width(opn_pkg::TB_W)) tb_if ();

    opn_clk_div u_clk_div (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .cen     ( cen     ),
        .slot_en ( slot_en ),
        .tick_a  ( tick_a  ),
        .tick_b  ( tick_b  )
    );

    opn_regs u_regs (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .din     ( din     ),
        .addr    ( addr    ),
        .cs_n    ( cs_n    ),
        .wr_n    ( wr_n    ),
        .slot_en ( slot_en ),   // Busy counts slots
        .ta      ( ta_if   ),
        .tb      ( tb_if   ),
        .dout    ( dout    ),
        .irq_n   ( irq_n   )
    );

    // Timer A, one tick per sample
    opn_timer #(
        .width ( opn_pkg::TA_W )
    ) u_timer_a (
        .clk   ( clk    ),
        .reset ( reset  ),
        .tick  ( tick_a ),
        .ctl   ( ta_if  )
    );

    // Timer B runs TB_PRESCALE times slower
    opn_timer #(
        .width ( opn_pkg::TB_W )
    ) u_timer_b (
        .clk   ( clk    ),
        .reset ( reset  ),
        .tick  ( tick_b ),
        .ctl   ( tb_if  )
    );

endmodule

//--- tb_opn_core.sv
// Testbench for the OPN control block
// Random cen, bus writes, reference overflow model and status checks

`timescale 1ns/1ns

module tb_opn_core;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       cen = 1'b0;
    logic [7:0] din = 8'h00;
    logic [1:0] addr = 2'b00;
    logic       cs_n = 1'b1;
    logic       wr_n = 1'b1;
    logic [7:0] dout;
    logic       irq_n;

    int         seed = 32'hb0ed_534f;
    int         errors = 0;
    int         checks = 0;
    int         cen_count = 0;
    logic [1:0] known_mask = 2'b00;  // Flags with a certain prediction
    logic [1:0] exp_flags = 2'b00;

    opn_core dut (
        .clk   ( clk   ),
        .reset ( reset ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always #2 clk = ~clk;

    always @(negedge clk) cen = ($random(seed) & 3) != 0;  // High about 3 in 4

    always @(posedge clk) begin
        if (reset) cen_count = 0;
        else if (cen) cen_count = cen_count + 1;
    end

    // cen cycles until the first overflow from a given start value
    function automatic int overflow_cens(input int value, input int width, input int per_tick);
        return ((1 << width) - value) * per_tick;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    task automatic check_window(input string what, input int got, input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("%s came after %0d cen cycles, outside %0d to %0d", what, got, lo, hi);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_write(2'b00, reg_addr);
        bus_write(2'b01, data);
    endtask

    task automatic wait_status(input logic [7:0] mask, input logic [7:0] want,
                               input int max_cycles, input string what);
        int cycles;
        cycles = 0;
        while ((dout & mask) !== want && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if ((dout & mask) !== want) begin
            errors++;
            $display("Timeout: %s did not happen within %0d clock cycles", what, max_cycles);
        end
    endtask

    // Values seen here were settled by the previous edge
    always @(posedge clk) begin
        if (!reset) begin
            check_value("dout[6:2]", dout[6:2], 5'h00);
            if (known_mask != 2'b00)
                check_value("dout[1:0]", dout[1:0] & known_mask, exp_flags & known_mask);
            if (known_mask == 2'b11)
                check_value("irq_n", irq_n, exp_flags == 2'b00);
        end
    end

    initial begin
        int t0;
        int lo;
        int hi;
        int quiet;
        int cycles;
        int a_cens;
        int b_cens;
        a_cens = opn_pkg::CEN_DIV * opn_pkg::SLOTS_PER_SAMPLE;
        b_cens = a_cens * opn_pkg::TB_PRESCALE;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("dout", dout, 8'h00);
        check_value("irq_n", irq_n, 1'b1);
        known_mask = 2'b11;

        write_reg(8'h10, 8'h5a);  // Unused address, still starts busy
        check_value("dout[7]", dout[7], 1'b1);
        t0 = cen_count;
        lo = (opn_pkg::BUSY_SLOTS - 1) * opn_pkg::CEN_DIV;
        hi = (opn_pkg::BUSY_SLOTS + 1) * opn_pkg::CEN_DIV;
        wait_status(8'h80, 8'h00, 2 * hi + 100, "busy clear");
        check_window("Busy clear", cen_count - t0, lo, hi);

        write_reg(opn_pkg::REG_TA_HI, 8'hff);
        write_reg(opn_pkg::REG_TA_LO, 8'h00);
        known_mask = 2'b10;
        write_reg(opn_pkg::REG_TIMER_CTL, 8'h05);  // Load and enable A
        t0 = cen_count;
        lo = overflow_cens(10'h3fc, opn_pkg::TA_W, a_cens) - a_cens;
        hi = overflow_cens(10'h3fc, opn_pkg::TA_W, a_cens) + a_cens;
        wait_status(8'h01, 8'h01, 2 * hi + 100, "flag A");
        check_window("Flag A", cen_count - t0, lo, hi);
        exp_flags  = 2'b01;
        known_mask = 2'b11;

        write_reg(opn_pkg::REG_TB, 8'hfe);
        known_mask = 2'b00;
        write_reg(opn_pkg::REG_TIMER_CTL, 8'h1a);  // Load and enable B, clear A
        t0 = cen_count;
        wait_status(8'h03, 8'h00, 8, "flag A clear");
        exp_flags  = 2'b00;
        known_mask = 2'b01;
        lo = overflow_cens(8'hfe, opn_pkg::TB_W, b_cens) - b_cens;
        hi = overflow_cens(8'hfe, opn_pkg::TB_W, b_cens) + b_cens;
        wait_status(8'h02, 8'h02, 2 * hi + 100, "flag B");
        check_window("Flag B", cen_count - t0, lo, hi);
        exp_flags  = 2'b10;
        known_mask = 2'b11;
        @(negedge clk);  // One compare with flag B and irq_n low

        known_mask = 2'b00;
        write_reg(opn_pkg::REG_TIMER_CTL, 8'h30);  // Clear both flags
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        check_value("dout[1:0]", dout[1:0], 2'b00);
        check_value("irq_n", irq_n, 1'b1);
        exp_flags  = 2'b00;
        known_mask = 2'b11;
        write_reg(opn_pkg::REG_TIMER_CTL, 8'h03);  // Both loaded, neither enabled
        t0 = cen_count;
        quiet = 2 * overflow_cens(10'h3fc, opn_pkg::TA_W, a_cens);
        cycles = 0;
        while (cen_count - t0 < quiet && cycles < 2 * quiet + 100) begin
            @(negedge clk);
            cycles++;
        end
        if (cen_count - t0 < quiet) begin
            errors++;
            $display("Timeout: cen stopped during the quiet period of the timers");
        end

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
opn_pkg.sv
timer_if.sv
opn_clk_div.sv
opn_regs.sv
opn_timer.sv
opn_core.sv
tb_opn_core.sv
